// File: common/lcd_pkg.sv
package lcd_pkg;

	typedef logic [7:0] lcd_byte_t;
	typedef logic [6:0] lcd_cfg_t;	// {lines, font, display, cursor, blink, inc, shift}
	typedef logic [3:0] lcd_fill_t;

	typedef struct packed {
		logic      rs;
		logic      rw;
		lcd_byte_t data;
	} lcd_cmd_t;

	typedef struct packed {
		logic      e;
		logic      rs;
		logic      rw;
		lcd_byte_t data;
	} lcd_pins_t;

	typedef enum logic [1:0] {
		SEQ_POWER_WAIT,
		SEQ_SETUP_ISSUE,
		SEQ_SETUP_WAIT,
		SEQ_RUN
	} seq_state_t;

	// all times in clock cycles
	localparam int T_POWER_UP   = 500;
	localparam int T_E_LOW_PRE  = 1;
	localparam int T_E_HIGH     = 13;
	localparam int T_E_LOW_POST = 13;
	localparam int T_SLOT       = 50;
	localparam int T_SLOT_LONG  = 200;
	localparam int T_E_CYCLE    = T_E_LOW_PRE + T_E_HIGH + T_E_LOW_POST;
	localparam int T_SLOT_SHORT = (T_SLOT > T_E_CYCLE) ? T_SLOT : T_E_CYCLE;

	localparam int CMD_FIFO_DEPTH = 8;
	localparam int CMD_PTR_W      = $clog2(CMD_FIFO_DEPTH);
	localparam int PWR_CNT_W      = $clog2(T_POWER_UP);
	localparam int SLOT_CNT_W     = $clog2(T_SLOT_LONG);

	typedef logic [CMD_PTR_W-1:0]  cmd_ptr_t;
	typedef logic [PWR_CNT_W-1:0]  pwr_cnt_t;
	typedef logic [SLOT_CNT_W-1:0] slot_cnt_t;

	// setup opcodes, option bits or'd in by the sequencer
	localparam lcd_byte_t LCD_FUNC_SET   = 8'h30;
	localparam lcd_byte_t LCD_DISP_CTRL  = 8'h08;
	localparam lcd_byte_t LCD_CLEAR      = 8'h01;
	localparam lcd_byte_t LCD_ENTRY_MODE = 8'h04;

endpackage

// File: common/apb_pkg.sv
package apb_pkg;

	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

	localparam apb_addr_t REG_CTRL   = 8'h00;
	localparam apb_addr_t REG_STATUS = 8'h04;
	localparam apb_addr_t REG_CMD    = 8'h08;

	localparam int CTRL_START_BIT = 8;	// start flag in CTRL

endpackage

// File: src/lcd_apb_regs.sv
`timescale 1ns/1ps

module lcd_apb_regs
	import lcd_pkg::*;
	import apb_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  apb_req_t  apb_req,
	output apb_rsp_t  apb_rsp,
	output lcd_cfg_t  cfg,
	output logic      start,
	input  logic      init_done,
	input  logic      busy,
	input  lcd_fill_t fill,
	output lcd_cmd_t  push_cmd,
	output logic      push_valid,
	input  logic      push_ready
);

	logic      access;
	logic      hit;
	logic      wr_ctrl;
	logic      wr_cmd;
	lcd_cfg_t  cfg_q;
	logic      start_q;
	apb_data_t ctrl_word;
	apb_data_t status_word;

	assign access = apb_req.psel & apb_req.penable;	// access phase only
	assign hit = (apb_req.paddr == REG_CTRL) ||
		(apb_req.paddr == REG_STATUS) ||
		(apb_req.paddr == REG_CMD);

	assign wr_ctrl = access & apb_req.pwrite & (apb_req.paddr == REG_CTRL);
	assign wr_cmd  = access & apb_req.pwrite & (apb_req.paddr == REG_CMD);

	// master holds the access phase, so valid stays up until the push
	assign push_valid = wr_cmd;
	assign push_cmd   = lcd_cmd_t'(apb_req.pwdata[$bits(lcd_cmd_t)-1:0]);

	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_q   <= '0;
			start_q <= 1'b0;
		end else begin
			start_q <= wr_ctrl & apb_req.pwdata[CTRL_START_BIT];	// single cycle
			if (wr_ctrl) begin
				cfg_q <= apb_req.pwdata[$bits(lcd_cfg_t)-1:0];
			end
		end
	end

	assign cfg   = cfg_q;
	assign start = start_q;

	// start is self clearing and reads back as 0
	assign ctrl_word   = {25'd0, cfg_q};
	assign status_word = {24'd0, fill, 2'b00, init_done, busy};

	always_comb begin
		apb_rsp        = '0;
		apb_rsp.pready = 1'b1;	// idle and single cycle accesses
		if (access) begin
			if (!hit) begin
				apb_rsp.pslverr = 1'b1;	// unmapped, no side effect
			end else if (wr_cmd) begin
				apb_rsp.pready = push_ready;	// stretch while fifo full
			end
			if (!apb_req.pwrite) begin
				case (apb_req.paddr)
					REG_CTRL:   apb_rsp.prdata = ctrl_word;
					REG_STATUS: apb_rsp.prdata = status_word;
					default:    apb_rsp.prdata = '0;
				endcase
			end
		end
	end

endmodule

// File: src/lcd_cmd_fifo.sv
`timescale 1ns/1ps

module lcd_cmd_fifo
	import lcd_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  lcd_cmd_t  push_cmd,
	input  logic      push_valid,
	output logic      push_ready,
	output lcd_cmd_t  q_cmd,
	output logic      q_valid,
	input  logic      q_ready,
	output lcd_fill_t fill
);

	lcd_cmd_t  mem [CMD_FIFO_DEPTH];
	cmd_ptr_t  wr_ptr;
	cmd_ptr_t  rd_ptr;
	lcd_fill_t count;
	logic      do_push;
	logic      do_pop;

	assign push_ready = (count != lcd_fill_t'(CMD_FIFO_DEPTH));
	assign q_valid    = (count != '0);
	assign do_push    = push_valid & push_ready;
	assign do_pop     = q_valid & q_ready;

	assign q_cmd = mem[rd_ptr];	// head visible the cycle after push
	assign fill  = count;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_cmd;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// none or both
			endcase
		end
	end

endmodule

// File: lcd_ctrl/lcd_init_seq.sv
`timescale 1ns/1ps

module lcd_init_seq
	import lcd_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  lcd_cfg_t cfg,
	input  logic     start,
	input  lcd_cmd_t q_cmd,
	input  logic     q_valid,
	output logic     q_ready,
	output lcd_cmd_t issue_cmd,
	output logic     issue_valid,
	input  logic     issue_ready,
	output logic     init_done
);

	seq_state_t state;
	pwr_cnt_t   pwr_cnt;
	logic       pwr_armed;
	logic [1:0] step;
	lcd_cmd_t   setup_cmd;

	// cfg = {lines, font, display, cursor, blink, inc, shift}
	function automatic lcd_byte_t setup_byte(input lcd_cfg_t c, input logic [1:0] idx);
		case (idx)
			2'd0:    setup_byte = LCD_FUNC_SET | {4'b0000, c[6], c[5], 2'b00};
			2'd1:    setup_byte = LCD_DISP_CTRL | {5'b00000, c[4:2]};
			2'd2:    setup_byte = LCD_CLEAR;
			default: setup_byte = LCD_ENTRY_MODE | {6'b000000, c[1:0]};
		endcase
	endfunction

	assign setup_cmd = '{rs: 1'b0, rw: 1'b0, data: setup_byte(cfg, step)};

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= SEQ_POWER_WAIT;
			pwr_cnt   <= '0;
			pwr_armed <= 1'b0;
			step      <= '0;
		end else begin
			case (state)
				SEQ_POWER_WAIT: begin
					if (start) begin
						pwr_armed <= 1'b1;	// count only once started
					end
					if (pwr_armed) begin
						if (pwr_cnt == pwr_cnt_t'(T_POWER_UP - 1)) begin
							state <= SEQ_SETUP_ISSUE;
							step  <= '0;
						end else begin
							pwr_cnt <= pwr_cnt + 1'b1;
						end
					end
				end
				SEQ_SETUP_ISSUE: begin
					if (issue_ready) begin
						step  <= step + 1'b1;
						state <= (step == 2'd3) ? SEQ_RUN : SEQ_SETUP_WAIT;
					end
				end
				SEQ_SETUP_WAIT: begin
					if (issue_ready) begin	// timer back to idle
						state <= SEQ_SETUP_ISSUE;
					end
				end
				default: state <= SEQ_RUN;	// stays here until reset
			endcase
		end
	end

	always_comb begin
		issue_cmd   = setup_cmd;
		issue_valid = 1'b0;
		q_ready     = 1'b0;
		case (state)
			SEQ_SETUP_ISSUE: issue_valid = 1'b1;
			SEQ_RUN: begin
				issue_cmd   = q_cmd;	// user commands pass unchanged
				issue_valid = q_valid;
				q_ready     = issue_ready;
			end
			default: issue_valid = 1'b0;
		endcase
	end

	assign init_done = (state == SEQ_RUN);

endmodule

// File: lcd_ctrl/lcd_bus_timer.sv
`timescale 1ns/1ps

module lcd_bus_timer
	import lcd_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  lcd_cmd_t  issue_cmd,
	input  logic      issue_valid,
	output logic      issue_ready,
	output lcd_pins_t pins,
	output logic      busy
);

	lcd_cmd_t  cmd_q;
	slot_cnt_t cnt;
	logic      active;
	logic      long_q;
	logic      is_long;
	logic      accept;
	logic      slot_end;
	logic      e_on;

	// clear and return home need the long slot
	assign is_long = ~issue_cmd.rs &&
		(issue_cmd.data[7:2] == 6'd0) &&
		(issue_cmd.data[1:0] != 2'b00);

	assign issue_ready = ~active;
	assign accept      = issue_valid & ~active;

	assign slot_end = long_q ? (cnt == slot_cnt_t'(T_SLOT_LONG - 1))
		: (cnt == slot_cnt_t'(T_SLOT_SHORT - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			cnt    <= '0;
			long_q <= 1'b0;
		end else if (accept) begin
			active <= 1'b1;
			cnt    <= '0;
			long_q <= is_long;
		end else if (active) begin
			if (slot_end) begin
				active <= 1'b0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_q <= issue_cmd;
		end
	end

	// low pre, high window, then low to slot end
	assign e_on = active &&
		(cnt >= slot_cnt_t'(T_E_LOW_PRE)) &&
		(cnt < slot_cnt_t'(T_E_LOW_PRE + T_E_HIGH));

	always_comb begin
		pins = '0;	// bus quiet between slots
		if (active) begin
			pins.e    = e_on;
			pins.rs   = cmd_q.rs;
			pins.rw   = cmd_q.rw;
			pins.data = cmd_q.data;
		end
	end

	assign busy = active;

endmodule

// File: src/lcd_top.sv
`timescale 1ns/1ps

module lcd_top
	import lcd_pkg::*;
	import apb_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  apb_req_t  apb_req,
	output apb_rsp_t  apb_rsp,
	output lcd_pins_t lcd_pins
);

	lcd_cfg_t  cfg;
	logic      start;
	logic      init_done;
	logic      busy;
	lcd_fill_t fill;

	lcd_cmd_t  push_cmd;
	logic      push_valid;
	logic      push_ready;
	lcd_cmd_t  q_cmd;
	logic      q_valid;
	logic      q_ready;
	lcd_cmd_t  issue_cmd;
	logic      issue_valid;
	logic      issue_ready;

	lcd_apb_regs u_regs (
		.clk        (clk),
		.reset      (reset),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.cfg        (cfg),
		.start      (start),
		.init_done  (init_done),
		.busy       (busy),
		.fill       (fill),
		.push_cmd   (push_cmd),
		.push_valid (push_valid),
		.push_ready (push_ready)
	);

	lcd_cmd_fifo u_fifo (
		.clk        (clk),
		.reset      (reset),
		.push_cmd   (push_cmd),
		.push_valid (push_valid),
		.push_ready (push_ready),
		.q_cmd      (q_cmd),
		.q_valid    (q_valid),
		.q_ready    (q_ready),
		.fill       (fill)
	);

	lcd_init_seq u_seq (
		.clk         (clk),
		.reset       (reset),
		.cfg         (cfg),
		.start       (start),
		.q_cmd       (q_cmd),
		.q_valid     (q_valid),
		.q_ready     (q_ready),
		.issue_cmd   (issue_cmd),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.init_done   (init_done)
	);

	lcd_bus_timer u_timer (
		.clk         (clk),
		.reset       (reset),
		.issue_cmd   (issue_cmd),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.pins        (lcd_pins),
		.busy        (busy)
	);

endmodule

// File: tb/lcd_sva.sv
`timescale 1ns/1ps

module lcd_sva
	import lcd_pkg::*;
(
	input logic      clk,
	input logic      reset,
	input lcd_pins_t pins,
	input logic      busy,
	input logic      issue_valid,
	input logic      issue_ready
);

	int unsigned fail_count = 0;	// read by the testbench

	// enable pulse width
	e_high_width: assert property (@(posedge clk) disable iff (reset)
		$rose(pins.e) |-> pins.e [*T_E_HIGH] ##1 !pins.e)
	else begin
		$error("e high width differs from %0d cycles", T_E_HIGH);
		fail_count++;
	end

	bus_stable: assert property (@(posedge clk) disable iff (reset)
		busy ##1 busy |-> $stable({pins.rs, pins.rw, pins.data}))
	else begin
		$error("rs, rw or data changed inside a slot");
		fail_count++;
	end

	// an accepted command keeps the timer closed for at least a short slot
	no_ready_in_slot: assert property (@(posedge clk) disable iff (reset)
		issue_valid && issue_ready |=> !issue_ready [*T_SLOT])
	else begin
		$error("issue_ready came back within %0d cycles of an accept", T_SLOT);
		fail_count++;
	end

endmodule

// File: tb/lcd_tb.sv
`timescale 1ns/1ps

module lcd_tb
	import lcd_pkg::*;
	import apb_pkg::*;
();

	localparam int N_CMDS      = 20 + 12 + 2;
	localparam int WATCHDOG_NS = (T_POWER_UP + 4 * T_SLOT_LONG + N_CMDS * T_SLOT_LONG + 1000) * 4;

	logic      clk = 1'b0;
	logic      reset;
	apb_req_t  apb_req;
	apb_rsp_t  apb_rsp;
	lcd_pins_t lcd_pins;

	lcd_cmd_t    exp_q [$];	// commands still owed to the display
	logic [31:0] rng = 32'h893a;
	int          cycle = 0;
	int          start_cycle = 0;
	logic        started = 1'b0;
	int          pulses = 0;
	int          high_len = 0;
	int          last_rise = 0;
	logic        last_long = 1'b0;
	logic        prev_e = 1'b0;

	lcd_top dut0 (
		.clk      (clk),
		.reset    (reset),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.lcd_pins (lcd_pins)
	);

	bind lcd_bus_timer lcd_sva u_sva (
		.clk         (clk),
		.reset       (reset),
		.pins        (pins),
		.busy        (busy),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready)
	);

	always #2 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// cfg bits {lines, font, display, cursor, blink, inc, shift}
	function automatic lcd_byte_t expected_setup(input lcd_cfg_t c, input int idx);
		case (idx)
			0:       return 8'h30 | ({7'd0, c[6]} << 3) | ({7'd0, c[5]} << 2);
			1:       return 8'h08 | {5'd0, c[4], c[3], c[2]};
			2:       return 8'h01;
			default: return 8'h04 | {6'd0, c[1], c[0]};
		endcase
	endfunction

	function automatic logic expected_long(input lcd_cmd_t c);
		return !c.rs && (c.data == 8'h01 || c.data == 8'h02 || c.data == 8'h03);
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err, output int waits);
		logic done;
		done = 1'b0;
		waits = 0;
		@(negedge clk);
		apb_req.psel    = 1'b1;	// setup phase
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		while (!done) begin
			#1;	// response settled by mid low phase
			done  = apb_rsp.pready;
			err   = apb_rsp.pslverr;
			rdata = apb_rsp.prdata;
			@(posedge clk);
			if (!done) begin
				waits++;
				@(negedge clk);
			end
		end
		@(negedge clk);
		apb_req = '0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata,
			output logic err, output int waits);
		apb_data_t unused;
		apb_access(1'b1, addr, wdata, unused, err, waits);
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic err);
		int waits;
		apb_access(1'b0, addr, '0, rdata, err, waits);
	endtask

	task automatic send_cmd(input lcd_cmd_t cmd, output int waits);
		logic err;
		exp_q.push_back(cmd);
		apb_write(REG_CMD, apb_data_t'(cmd), err, waits);
		assert (!err) else fail_run($sformatf("error at %0t: CMD write got pslverr", $time));
	endtask

	task automatic wait_drain();
		apb_data_t st;
		logic      err;
		while (exp_q.size() != 0) @(negedge clk);
		do begin
			apb_read(REG_STATUS, st, err);
		end while (st[0] || st[7:4] != 4'd0);	// until timer idle and fifo empty
		assert (lcd_pins == '0)
		else fail_run($sformatf("error at %0t: bus pins %h between slots", $time, lcd_pins));
	endtask

	// pin monitor samples at the falling edge where the bus is stable
	always @(negedge clk) begin
		if (lcd_pins.e && !prev_e) begin
			assert (started && exp_q.size() != 0)
			else fail_run("the display saw an e pulse that no command asked for");
			assert (lcd_pins.rs == exp_q[0].rs && lcd_pins.rw == exp_q[0].rw &&
					lcd_pins.data == exp_q[0].data)
			else fail_run($sformatf("error at %0t: pins rs=%b rw=%b data=%h, expected %b %b %h",
				$time, lcd_pins.rs, lcd_pins.rw, lcd_pins.data,
				exp_q[0].rs, exp_q[0].rw, exp_q[0].data));
			if (pulses == 0) begin
				assert (cycle - start_cycle >= T_POWER_UP)
				else fail_run($sformatf("error at %0t: first e rise %0d cycles after start",
					$time, cycle - start_cycle));
			end else begin
				assert (cycle - last_rise >= (last_long ? T_SLOT_LONG : T_SLOT))
				else fail_run($sformatf("error at %0t: e rises only %0d cycles apart",
					$time, cycle - last_rise));
			end
			last_long = expected_long(exp_q[0]);
			last_rise = cycle;
			void'(exp_q.pop_front());
			pulses++;
			high_len = 1;
		end else if (lcd_pins.e) begin
			high_len++;
		end else if (prev_e) begin
			assert (high_len == T_E_HIGH)
			else fail_run($sformatf("error at %0t: e high for %0d cycles", $time, high_len));
		end
		prev_e = lcd_pins.e;
	end

	always @(negedge clk) begin
		if (dut0.u_timer.u_sva.fail_count != 0) fail_run("a bus timer assertion failed");
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("watchdog expired before the display finished all commands");
	end

	initial begin
		apb_data_t rdata;
		logic      err;
		int        waits;
		int        stalled;
		lcd_cfg_t  cfg;
		stalled = 0;
		apb_req = '0;
		reset   = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// reset state
		assert (apb_rsp.pready && !apb_rsp.pslverr && !lcd_pins.e)
		else fail_run($sformatf("error at %0t: bus not idle after reset", $time));
		apb_read(REG_STATUS, rdata, err);
		assert (!err && !rdata[1])
		else fail_run($sformatf("error at %0t: STATUS after reset reads %h", $time, rdata));

		// initialization with a random setup
		rng = xorshift(rng);
		cfg = rng[6:0];
		for (int i = 0; i < 4; i++) begin
			exp_q.push_back('{rs: 1'b0, rw: 1'b0, data: expected_setup(cfg, i)});
		end
		started = 1'b1;
		apb_write(REG_CTRL, apb_data_t'(cfg) | (32'd1 << 8), err, waits);
		start_cycle = cycle;
		apb_read(REG_CTRL, rdata, err);
		assert (rdata[6:0] == cfg)
		else fail_run($sformatf("error at %0t: CTRL reads %h", $time, rdata));
		do apb_read(REG_STATUS, rdata, err); while (!rdata[1]);
		wait_drain();

		// random command path
		for (int i = 0; i < 20; i++) begin
			rng = xorshift(rng);
			send_cmd(lcd_cmd_t'(rng[9:0]), waits);
		end
		wait_drain();

		// back-to-back writes past the fifo depth
		for (int i = 0; i < 12; i++) begin
			rng = xorshift(rng);
			send_cmd(lcd_cmd_t'(rng[9:0]), waits);
			if (waits > 0) stalled++;
		end
		assert (stalled > 0) else fail_run("no CMD write was held by a full FIFO");
		apb_read(REG_STATUS, rdata, err);	// last write was held, so the fifo is full again
		assert (rdata[7:4] == lcd_fill_t'(CMD_FIFO_DEPTH) && rdata[0])
		else fail_run($sformatf("error at %0t: STATUS after a held write reads %h",
			$time, rdata));
		wait_drain();

		// clear then an ordinary data write
		send_cmd('{rs: 1'b0, rw: 1'b0, data: 8'h01}, waits);
		send_cmd('{rs: 1'b1, rw: 1'b0, data: 8'h41}, waits);
		wait_drain();

		// unmapped offsets
		apb_write(8'h0c, 32'h0000_0155, err, waits);
		assert (err) else fail_run($sformatf("error at %0t: write to 0x0c without pslverr", $time));
		apb_read(8'h10, rdata, err);
		assert (err) else fail_run($sformatf("error at %0t: read of 0x10 without pslverr", $time));
		repeat (T_SLOT_LONG) @(negedge clk);	// window for a stray pulse

		if (dut0.u_timer.u_sva.fail_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			fail_run("a bus timer assertion failed");
		end
	end

endmodule

// File: lcd.f
common/lcd_pkg.sv
common/apb_pkg.sv
src/lcd_apb_regs.sv
src/lcd_cmd_fifo.sv
lcd_ctrl/lcd_init_seq.sv
lcd_ctrl/lcd_bus_timer.sv
src/lcd_top.sv
tb/lcd_sva.sv
tb/lcd_tb.sv

// File: Bender.yml
package:
  name: lcd

sources:
  - common/lcd_pkg.sv
  - common/apb_pkg.sv
  - src/lcd_apb_regs.sv
  - src/lcd_cmd_fifo.sv
  - lcd_ctrl/lcd_init_seq.sv
  - lcd_ctrl/lcd_bus_timer.sv
  - src/lcd_top.sv
  - target: test
    files:
      - tb/lcd_sva.sv
      - tb/lcd_tb.sv
